// File: Makefile
TOP := fft_tile_tb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: logic/block_counter.sv
/*
 * Word and block counter that steers the packet encoder through one reply.
 */
module block_counter (
   input  logic                    clk_ctrl,
   input  logic                    clk_ctrl_rst_low,
   input  logic                    load,
   input  noc_acc_pkg::size_code_t size_code,
   input  logic                    advance,
   output logic [2:0]              word_sel,
   output logic                    last_word,
   output logic                    last_block
);
   import noc_acc_pkg::*;

   logic [7:0] blocks_left;   // Up to 128 blocks at size code 10

   assign last_word  = (word_sel == 3'(WORDS_PER_BLOCK - 1));
   assign last_block = (blocks_left == 8'd1);

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         word_sel    <= '0;
         blocks_left <= '0;
      end else if (load) begin
         word_sel    <= '0;
         blocks_left <= 8'd1 << (size_code - MIN_SIZE_CODE);
      end else if (advance) begin
         word_sel <= word_sel + 3'd1;
         if (last_word)
            blocks_left <= blocks_left - 8'd1;   // Block done
      end
   end

endmodule

// File: logic/dft4_core.sv
/*
 * Four-point integer DFT on one block of four complex samples.
 * Two register stages, so a result appears exactly two cycles after its block.
 */
module dft4_core (
   input  logic                clk_ctrl,
   input  logic                clk_ctrl_rst_low,
   input  logic                blk_valid,
   input  noc_acc_pkg::block_t blk_data,
   output logic                res_valid,
   output noc_acc_pkg::block_t res_data
);
   import noc_acc_pkg::*;

   // Stage 1 words: x0+x2, x1+x3, x0-x2, x1-x3, each as Re then Im
   block_t st1;
   logic   st1_valid;

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         st1_valid <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         st1_valid <= blk_valid;
         res_valid <= st1_valid;
      end
   end

   //////////////////////////////
   // Butterflies, wrapping adds
   //////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      for (int p = 0; p < 2; p++) begin   // p selects Re or Im
         st1[0 + p] <= blk_data[0 + p] + blk_data[4 + p];
         st1[2 + p] <= blk_data[2 + p] + blk_data[6 + p];
         st1[4 + p] <= blk_data[0 + p] - blk_data[4 + p];
         st1[6 + p] <= blk_data[2 + p] - blk_data[6 + p];
      end

      res_data[0] <= st1[0] + st1[2];     // X0
      res_data[1] <= st1[1] + st1[3];
      res_data[4] <= st1[0] - st1[2];     // X2
      res_data[5] <= st1[1] - st1[3];

      // Rotation by -j swaps Re and Im of the odd difference
      res_data[2] <= st1[4] + st1[7];     // X1
      res_data[3] <= st1[5] - st1[6];
      res_data[6] <= st1[4] - st1[7];     // X3
      res_data[7] <= st1[5] + st1[6];
   end

endmodule

// File: logic/fft_tile_top.sv
/*
 * Single-clock NoC FFT tile. Decoder, DFT core, header and block FIFOs,
 * encoder and block counter, with the sizing parameters set here.
 */
module fft_tile_top #(
   parameter noc_acc_pkg::node_id_t TILE_ID = 6'd1,
   parameter int HDR_FIFO_DEPTH     = 32,
   parameter int BLK_FIFO_DEPTH     = 8,
   parameter int ALMOST_FULL_MARGIN = 4
) (
   input  logic               clk_ctrl,
   input  logic               clk_ctrl_rst_low,
   input  logic               in_valid,
   input  noc_acc_pkg::word_t in_data,
   input  logic               in_last,
   output logic               in_ready,
   input  logic               out_ready,
   output logic               out_valid,
   output noc_acc_pkg::word_t out_data,
   output logic               out_last
);
   import noc_acc_pkg::*;

   // Header path
   logic       hdr_push;
   word_t      hdr_word;
   logic       hdr_pop;
   word_t      hdr_dout;
   logic       hdr_empty;
   logic       hdr_full;
   logic       hdr_almost_full;

   // Block path
   logic       blk_valid;
   block_t     blk_data;
   logic       res_valid;
   block_t     res_data;
   logic       blk_pop;
   block_t     blk_dout;
   logic       blk_empty;
   logic       blk_full;
   logic       blk_almost_full;

   // Encoder steering
   logic       load;
   size_code_t size_code;
   logic       advance;
   logic [2:0] word_sel;
   logic       last_word;
   logic       last_block;

   //////////////////////////////
   // Input side
   //////////////////////////////

   packet_decoder #(.TILE_ID(TILE_ID)) decoder (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_last         (in_last),
      .hdr_almost_full (hdr_almost_full),
      .blk_almost_full (blk_almost_full),
      .in_ready        (in_ready),
      .hdr_push        (hdr_push),
      .hdr_word        (hdr_word),
      .blk_valid       (blk_valid),
      .blk_data        (blk_data)
   );

   dft4_core dft4 (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .blk_valid       (blk_valid),
      .blk_data        (blk_data),
      .res_valid       (res_valid),
      .res_data        (res_data)
   );

   sync_fifo #(
      .WIDTH             ($bits(word_t)),
      .DEPTH             (HDR_FIFO_DEPTH),
      .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
   ) hdr_fifo (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .push            (hdr_push),
      .din             (hdr_word),
      .pop             (hdr_pop),
      .dout            (hdr_dout),
      .empty           (hdr_empty),
      .full            (hdr_full),
      .almost_full     (hdr_almost_full)
   );

   sync_fifo #(
      .WIDTH             ($bits(block_t)),
      .DEPTH             (BLK_FIFO_DEPTH),
      .ALMOST_FULL_MARGIN(ALMOST_FULL_MARGIN)
   ) blk_fifo (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .push            (res_valid),
      .din             (res_data),
      .pop             (blk_pop),
      .dout            (blk_dout),
      .empty           (blk_empty),
      .full            (blk_full),
      .almost_full     (blk_almost_full)
   );

   //////////////////////////////
   // Output side
   //////////////////////////////

   packet_encoder encoder (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .hdr_empty       (hdr_empty),
      .hdr_dout        (hdr_dout),
      .blk_empty       (blk_empty),
      .blk_dout        (blk_dout),
      .out_ready       (out_ready),
      .word_sel        (word_sel),
      .last_word       (last_word),
      .last_block      (last_block),
      .hdr_pop         (hdr_pop),
      .blk_pop         (blk_pop),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_last        (out_last),
      .load            (load),
      .size_code       (size_code),
      .advance         (advance)
   );

   block_counter counter (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .load            (load),
      .size_code       (size_code),
      .advance         (advance),
      .word_sel        (word_sel),
      .last_word       (last_word),
      .last_block      (last_block)
   );

endmodule

// File: logic/noc_acc_pkg.sv
/*
 * Shared types, route and opcode codes, and packet constants for the NoC FFT tile.
 * Modules import it inside their body and use scoped names in their port lists.
 */
package noc_acc_pkg;

   //////////////////////////////
   // Stream payload types
   //////////////////////////////

   typedef logic [31:0] word_t;             // One stream word
   typedef logic [7:0][31:0] block_t;       // Word 0 sits in the lowest slot

   typedef logic [3:0] size_code_t;         // Valid range 3 to 10
   typedef logic [5:0] node_id_t;           // Tile or destination identity

   // Route code carried in header word 1, bits 9:8
   typedef enum logic [1:0] {
      route_loop    = 2'd0,
      route_forward = 2'd1,
      route_final   = 2'd2
   } route_e;

   // Opcode placed in reply word A
   typedef enum logic [2:0] {
      op_qput = 3'd3,
      op_mput = 3'd4
   } opcode_e;

   //////////////////////////////
   // Packet constants
   //////////////////////////////

   localparam int WORDS_PER_BLOCK = 8;      // Four complex samples, Re then Im
   localparam int LONG_FLAG_BIT   = 28;     // In header word 0

   // Payload of a short packet that flips the enable
   localparam word_t CTRL_TOGGLE_WORD = 32'h8000_0000;

   // Size code of a one-block packet
   localparam size_code_t MIN_SIZE_CODE = 4'd3;

endpackage

// File: logic/packet_decoder.sv
/*
 * Input side of the tile. Parses the stream into control and data packets,
 * flips the enable, writes the two-word reply header into the header FIFO
 * and hands complete eight-word blocks to the DFT core.
 */
module packet_decoder #(
   parameter noc_acc_pkg::node_id_t TILE_ID = 6'd1
) (
   input  logic                clk_ctrl,
   input  logic                clk_ctrl_rst_low,
   input  logic                in_valid,
   input  noc_acc_pkg::word_t  in_data,
   input  logic                in_last,
   input  logic                hdr_almost_full,
   input  logic                blk_almost_full,
   output logic                in_ready,
   output logic                hdr_push,
   output noc_acc_pkg::word_t  hdr_word,
   output logic                blk_valid,
   output noc_acc_pkg::block_t blk_data
);
   import noc_acc_pkg::*;

   typedef enum logic [2:0] {
      dec_idle,
      dec_ctrl,
      dec_hdr2,
      dec_data,
      dec_drop
   } dec_state_e;

   dec_state_e state;
   logic       enable;                // Accelerator on
   logic       accept;
   logic       send_word_b;           // Word B goes out the cycle after word A
   logic [2:0] word_idx;              // Slot of the next data word
   word_t      hdr0;                  // Header word 0 of the current packet
   logic [1:0] reply_code;
   node_id_t   reply_dest;

   route_e     route;
   opcode_e    reply_op;
   node_id_t   reply_field;
   logic [1:0] next_code;
   node_id_t   next_dest;
   size_code_t size_code;

   assign accept    = in_valid & in_ready;
   assign size_code = hdr0[11:8];
   assign route     = route_e'(in_data[9:8]);

   // Back-pressure only between packets
   assign in_ready = (state != dec_idle) | ~(hdr_almost_full | blk_almost_full);

   //////////////////////////////
   // Reply header rewrite
   //////////////////////////////

   always_comb begin
      reply_op    = op_mput;
      reply_field = '0;
      next_code   = 2'd0;
      next_dest   = '0;
      case (route)
         route_forward: begin     // Answer goes back to the source
            reply_field = in_data[5:0];
            next_code   = 2'd2;
            next_dest   = hdr0[23:18];
         end
         route_final: begin
            reply_op    = op_qput;
            reply_field = in_data[5:0];
         end
         default: reply_op = op_mput;   // Loop back
      endcase
   end

   always_comb begin
      hdr_push = send_word_b;
      hdr_word = {22'd0, reply_code, 2'd0, reply_dest};   // Word B
      if (state == dec_hdr2 && accept) begin
         hdr_push = 1'b1;
         hdr_word = {3'b000, 1'b1, reply_op, 1'b0, TILE_ID, 6'd0,
                     size_code, 2'd0, reply_field};
      end
   end

   //////////////////////////////
   // Packet FSM
   //////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state       <= dec_idle;
         enable      <= 1'b0;
         send_word_b <= 1'b0;
         word_idx    <= '0;
         blk_valid   <= 1'b0;
      end else begin
         send_word_b <= (state == dec_hdr2) && accept;
         blk_valid   <= (state == dec_data) && accept &&
                        (word_idx == 3'(WORDS_PER_BLOCK - 1));
         if (accept) begin
            case (state)
               dec_idle: begin
                  if (!in_last) begin    // A lone header word is ignored
                     if (!in_data[LONG_FLAG_BIT])
                        state <= dec_ctrl;
                     else if (enable)
                        state <= dec_hdr2;
                     else
                        state <= dec_drop;
                  end
               end
               dec_ctrl: begin
                  if (in_data == CTRL_TOGGLE_WORD)
                     enable <= ~enable;
                  if (in_last)
                     state <= dec_idle;
               end
               dec_hdr2: begin
                  word_idx <= '0;
                  state    <= dec_data;
               end
               dec_data: begin
                  word_idx <= word_idx + 3'd1;   // Wraps into the next block
                  if (word_idx == 3'(WORDS_PER_BLOCK - 1) && in_last)
                     state <= dec_idle;
               end
               dec_drop: if (in_last) state <= dec_idle;
               default:  state <= dec_idle;
            endcase
         end
      end
   end

   // Header fields and block words
   always_ff @(posedge clk_ctrl) begin
      if (state == dec_idle && accept)
         hdr0 <= in_data;
      if (state == dec_hdr2 && accept) begin
         reply_code <= next_code;
         reply_dest <= next_dest;
      end
      if (state == dec_data && accept)
         blk_data[word_idx] <= in_data;
   end

endmodule

// File: logic/packet_encoder.sv
/*
 * Output side of the tile. Sends the reply header from the header FIFO,
 * then the result blocks word by word, holding each word under back-pressure.
 */
module packet_encoder (
   input  logic                    clk_ctrl,
   input  logic                    clk_ctrl_rst_low,
   input  logic                    hdr_empty,
   input  noc_acc_pkg::word_t      hdr_dout,
   input  logic                    blk_empty,
   input  noc_acc_pkg::block_t     blk_dout,
   input  logic                    out_ready,
   input  logic [2:0]              word_sel,
   input  logic                    last_word,
   input  logic                    last_block,
   output logic                    hdr_pop,
   output logic                    blk_pop,
   output logic                    out_valid,
   output noc_acc_pkg::word_t      out_data,
   output logic                    out_last,
   output logic                    load,
   output noc_acc_pkg::size_code_t size_code,
   output logic                    advance
);
   typedef enum logic [2:0] {
      enc_idle,
      enc_hdr_a,
      enc_hdr_b,
      enc_data,
      enc_wait_blk
   } enc_state_e;

   enc_state_e state;
   enc_state_e next_state;

   assign size_code = hdr_dout[11:8];   // Counter takes it on word A

   always_comb begin
      next_state = state;
      hdr_pop    = 1'b0;
      blk_pop    = 1'b0;
      out_valid  = 1'b0;
      out_data   = blk_dout[word_sel];
      out_last   = 1'b0;
      load       = 1'b0;
      advance    = 1'b0;
      case (state)
         enc_idle: begin
            if (!hdr_empty && !blk_empty)   // First block is ready
               next_state = enc_hdr_a;
         end
         enc_hdr_a: begin
            out_valid = 1'b1;
            out_data  = hdr_dout;
            if (out_ready) begin
               hdr_pop    = 1'b1;
               load       = 1'b1;
               next_state = enc_hdr_b;
            end
         end
         enc_hdr_b: begin
            out_valid = 1'b1;
            out_data  = hdr_dout;
            if (out_ready) begin
               hdr_pop    = 1'b1;
               next_state = enc_data;
            end
         end
         enc_data: begin
            out_valid = 1'b1;
            out_last  = last_word & last_block;
            if (out_ready) begin
               advance = 1'b1;
               if (last_word) begin
                  blk_pop    = 1'b1;
                  next_state = last_block ? enc_idle : enc_wait_blk;
               end
            end
         end
         enc_wait_blk: begin
            // Word 0 of the next block goes out as soon as it lands
            out_valid = ~blk_empty;
            if (!blk_empty) begin
               advance    = out_ready;
               next_state = enc_data;
            end
         end
         default: next_state = enc_idle;
      endcase
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low)
         state <= enc_idle;
      else
         state <= next_state;
   end

endmodule

// File: logic/sync_fifo.sv
/*
 * Single-clock circular FIFO with first-word fall-through output.
 * almost_full rises once the free entries drop to the margin or fewer.
 */
module sync_fifo #(
   parameter int WIDTH              = 32,
   parameter int DEPTH              = 8,
   parameter int ALMOST_FULL_MARGIN = 2
) (
   input  logic             clk_ctrl,
   input  logic             clk_ctrl_rst_low,
   input  logic             push,
   input  logic [WIDTH-1:0] din,
   input  logic             pop,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full,
   output logic             almost_full
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;            // Occupancy
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign do_push     = push & ~full;       // Overflow write is lost
   assign do_pop      = pop & ~empty;
   assign empty       = (count == '0);
   assign full        = (count == CNT_W'(DEPTH));
   assign almost_full = (int'(count) >= DEPTH - ALMOST_FULL_MARGIN);
   assign dout        = mem[rd_ptr];        // Head, no read latency

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= ptr_next(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_next(rd_ptr);
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   always_ff @(posedge clk_ctrl) begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

endmodule

// File: sim.f
logic/noc_acc_pkg.sv
logic/packet_decoder.sv
logic/dft4_core.sv
logic/sync_fifo.sv
logic/block_counter.sv
logic/packet_encoder.sv
logic/fft_tile_top.sv
verif/fft_tile_props.sv
verif/fft_tile_tb.sv

// File: verif/fft_tile_props.sv
/*
 * Assertions on the output stream handshake and FIFO safety.
 * Bound into the tile top level. The testbench reads fail_count at the end.
 */
module fft_tile_props (
   input logic               clk_ctrl,
   input logic               clk_ctrl_rst_low,
   input logic               out_valid,
   input logic               out_ready,
   input noc_acc_pkg::word_t out_data,
   input logic               out_last,
   input logic               hdr_push,
   input logic               hdr_full,
   input logic               res_valid,
   input logic               blk_full
);
   int fail_count = 0;   // Failed assertions so far

   // A stalled word stays on the bus unchanged
   out_hold: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
   else begin
      fail_count++;
      $error("output word changed while out_ready was low");
   end

   hdr_no_overflow: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      !(hdr_push && hdr_full))
   else begin
      fail_count++;
      $error("header FIFO pushed while full");
   end

   blk_no_overflow: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      !(res_valid && blk_full))
   else begin
      fail_count++;
      $error("block FIFO pushed while full");
   end

   last_needs_valid: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      out_last |-> out_valid)
   else begin
      fail_count++;
      $error("out_last high without out_valid");
   end

endmodule

bind fft_tile_top fft_tile_props props (
   .clk_ctrl        (clk_ctrl),
   .clk_ctrl_rst_low(clk_ctrl_rst_low),
   .out_valid       (out_valid),
   .out_ready       (out_ready),
   .out_data        (out_data),
   .out_last        (out_last),
   .hdr_push        (hdr_push),
   .hdr_full        (hdr_full),
   .res_valid       (res_valid),
   .blk_full        (blk_full)
);

// File: verif/fft_tile_tb.sv
/*
 * Random-stimulus testbench for the NoC FFT tile. Sends control and data packets,
 * predicts every reply word from the route rules and DFT formulas, checks the output.
 */
module fft_tile_tb;
   import noc_acc_pkg::*;

   localparam int SEED          = 70830;
   localparam int READY_TIMEOUT = 1000;
   localparam int DRAIN_TIMEOUT = 4000;
   localparam logic [5:0] TILE_ID = 6'd5;

   logic  clk_ctrl = 1'b0;
   logic  clk_ctrl_rst_low;
   logic  in_valid;
   word_t in_data;
   logic  in_last;
   logic  in_ready;
   logic  out_ready;
   logic  out_valid;
   word_t out_data;
   logic  out_last;

   word_t exp_data [$];          // Reply words still to come in order
   logic  exp_last [$];
   string test_name = "reset";
   logic  model_en = 1'b0;       // Tile enable as the model tracks it
   logic  ready_random = 1'b0;
   int    checks = 0;
   int    errors = 0;

   always #4 clk_ctrl = ~clk_ctrl;

   fft_tile_top #(.TILE_ID(TILE_ID)) dut (
      .clk_ctrl        (clk_ctrl),
      .clk_ctrl_rst_low(clk_ctrl_rst_low),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_last         (in_last),
      .in_ready        (in_ready),
      .out_ready       (out_ready),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_last        (out_last)
   );

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Four-point DFT written out per output in Re then Im order
   task automatic queue_block(input word_t x [8], input logic final_blk);
      word_t y [8];
      y[0] = x[0] + x[2] + x[4] + x[6];
      y[1] = x[1] + x[3] + x[5] + x[7];
      y[2] = x[0] - x[4] + x[3] - x[7];     // (x0-x2) - j(x1-x3)
      y[3] = x[1] - x[5] - x[2] + x[6];
      y[4] = x[0] - x[2] + x[4] - x[6];
      y[5] = x[1] - x[3] + x[5] - x[7];
      y[6] = x[0] - x[4] - x[3] + x[7];     // (x0-x2) + j(x1-x3)
      y[7] = x[1] - x[5] + x[2] - x[6];
      for (int i = 0; i < 8; i++) begin
         exp_data.push_back(y[i]);
         exp_last.push_back(final_blk && i == 7);
      end
   endtask

   //////////////////////////////
   // Input driver
   //////////////////////////////

   // Starts on a falling edge and returns on the falling edge after the transfer
   task automatic send_word(input word_t data, input logic last);
      int waited;
      waited    = 0;
      in_valid  = 1'b1;
      in_data   = data;
      in_last   = last;
      while (!in_ready && waited < READY_TIMEOUT) begin
         @(negedge clk_ctrl);
         waited++;
      end
      if (!in_ready) begin
         errors++;
         $display("ERROR: %s in_ready stayed low for %0d cycles", test_name, waited);
      end
      @(posedge clk_ctrl);
      @(negedge clk_ctrl);
   endtask

   // Once a packet has started the decoder keeps accepting
   task automatic check_ready_held();
      check_value({test_name, " in_ready"}, 32'd1, {31'd0, in_ready});
   endtask

   task automatic idle_input();
      in_valid = 1'b0;
      in_last  = 1'b0;
   endtask

   task automatic send_toggle();
      send_word($urandom & 32'hEFFF_FFFF, 1'b0);   // Short packet with the long flag clear
      check_ready_held();
      send_word(32'h8000_0000, 1'b1);
      model_en = ~model_en;
      idle_input();
   endtask

   task automatic send_long_packet(input logic [3:0] size, input logic [1:0] route);
      word_t      hdr0;
      word_t      hdr1;
      word_t      blk [8];
      word_t      words [$];
      logic [5:0] field;
      logic [5:0] source;
      logic [2:0] op;
      logic [5:0] reply_field;
      logic [1:0] code;
      logic [5:0] dest;
      int         nblk;
      field  = 6'($urandom);
      source = 6'($urandom);
      hdr0   = ($urandom & 32'hEF03_F0FF) | 32'h1000_0000 |
               {8'd0, source, 18'd0} | {20'd0, size, 8'd0};
      hdr1   = ($urandom & 32'hFFFF_FCC0) | {22'd0, route, 8'd0} | {26'd0, field};
      op          = 3'd4;                    // MPUT unless final
      reply_field = 6'd0;
      code        = 2'd0;
      dest        = 6'd0;
      if (route == 2'd1) begin               // Forward back to the source
         reply_field = field;
         code        = 2'd2;
         dest        = source;
      end else if (route == 2'd2) begin
         op          = 3'd3;
         reply_field = field;
      end
      nblk = 1 << (int'(size) - 3);
      if (model_en) begin
         exp_data.push_back({3'b000, 1'b1, op, 1'b0, TILE_ID, 6'd0, size, 2'd0, reply_field});
         exp_last.push_back(1'b0);
         exp_data.push_back({22'd0, code, 2'd0, dest});
         exp_last.push_back(1'b0);
      end
      for (int b = 0; b < nblk; b++) begin
         for (int i = 0; i < 8; i++) begin
            blk[i] = $urandom;
            words.push_back(blk[i]);
         end
         if (model_en)
            queue_block(blk, b == nblk - 1);
      end
      send_word(hdr0, 1'b0);
      check_ready_held();
      send_word(hdr1, 1'b0);
      foreach (words[i]) begin
         check_ready_held();
         send_word(words[i], i == words.size() - 1);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_data.size() != 0 && waited < DRAIN_TIMEOUT) begin
         @(negedge clk_ctrl);
         waited++;
      end
      if (exp_data.size() != 0) begin
         errors++;
         $display("ERROR: %s timed out with %0d reply words missing", test_name,
                  exp_data.size());
         exp_data.delete();
         exp_last.delete();
      end
   endtask

   // Any reply inside this window is unexpected
   task automatic wait_quiet(input int cycles);
      for (int n = 0; n < cycles; n++)
         @(negedge clk_ctrl);
   endtask

   //////////////////////////////
   // Output side and monitor
   //////////////////////////////

   initial begin : monitor
      word_t exp_w;
      logic  exp_l;
      out_ready = 1'b1;
      forever begin
         @(negedge clk_ctrl);
         out_ready = ready_random ? ($urandom_range(3, 0) != 0) : 1'b1;
         if (clk_ctrl_rst_low && out_valid && out_ready) begin   // Transfers next edge
            if (exp_data.size() == 0) begin
               errors++;
               $display("ERROR: %s unexpected output word %h", test_name, out_data);
            end else begin
               exp_w = exp_data.pop_front();
               exp_l = exp_last.pop_front();
               check_value({test_name, " out_data"}, exp_w, out_data);
               check_value({test_name, " out_last"}, {31'd0, exp_l}, {31'd0, out_last});
            end
         end
      end
   end

   initial begin : stimulus
      int assert_fails;
      void'($urandom(SEED));
      clk_ctrl_rst_low = 1'b0;
      in_valid         = 1'b0;
      in_data          = '0;
      in_last          = 1'b0;
      repeat (8) @(posedge clk_ctrl);
      @(negedge clk_ctrl);
      clk_ctrl_rst_low = 1'b1;
      @(negedge clk_ctrl);

      // Idle tile with empty FIFOs
      check_value({test_name, " in_ready"}, 32'd1, {31'd0, in_ready});
      check_value({test_name, " out_valid"}, 32'd0, {31'd0, out_valid});
      check_value({test_name, " out_last"}, 32'd0, {31'd0, out_last});

      test_name = "drop_while_disabled";
      send_long_packet(4'd3, 2'd1);
      idle_input();
      wait_quiet(60);
      send_toggle();

      test_name = "forward_route";
      send_long_packet(4'd3, 2'd1);
      idle_input();
      wait_drain();
      test_name = "final_route";
      send_long_packet(4'd3, 2'd2);
      idle_input();
      wait_drain();
      test_name = "loop_route";
      send_long_packet(4'd3, 2'd0);
      send_long_packet(4'd4, 2'd3);
      idle_input();
      wait_drain();

      test_name = "random_blocks";
      for (int n = 0; n < 6; n++) begin
         send_long_packet(4'(3 + n % 3), 2'($urandom));
         idle_input();
         wait_drain();
      end

      test_name    = "back_pressure";
      ready_random = 1'b1;
      for (int n = 0; n < 12; n++)
         send_long_packet(4'($urandom_range(5, 3)), 2'($urandom));
      idle_input();
      wait_drain();
      ready_random = 1'b0;

      test_name = "drop_after_disable";
      send_toggle();
      send_long_packet(4'd4, 2'd1);
      idle_input();
      wait_quiet(100);

      assert_fails = dut.props.fail_count;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
